// ==== bench/cps_sound_sva.sv ====
/*
  bound assertions for cps_sound: select exclusivity, outputs right after
  reset and a minimum of 48 clocks between pcm_cen pulses
*/
module cps_sound_sva (
    input logic clk,
    input logic rst,
    input logic rom_cs,
    input logic ram_cs,
    input logic fm_cs,
    input logic oki_cs,
    input logic latch0_cs,
    input logic latch1_cs,
    input logic peak,
    input logic pcm_cen
);
    timeunit 1ns;
    timeprecision 1ps;

    int         err_excl = 0;
    int         err_rst = 0;
    int         err_cen = 0;
    logic [6:0] gap_cnt;  // clocks since the last pulse, saturating
    logic       cen_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gap_cnt  <= '0;
            cen_seen <= 1'b0;
        end else if (pcm_cen) begin
            gap_cnt  <= '0;
            cen_seen <= 1'b1;
        end else if (gap_cnt != 7'h7f) begin
            gap_cnt <= gap_cnt + 7'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, fm_cs, oki_cs, latch0_cs, latch1_cs}))
    else begin
        err_excl++;
        $error("more than one chip select active");
    end

    // first clock out of reset
    assert property (@(posedge clk)
        $fell(rst) |-> !peak && !(rom_cs || ram_cs || fm_cs || oki_cs || latch0_cs || latch1_cs))
    else begin
        err_rst++;
        $error("peak or a chip select high right after reset");
    end

    assert property (@(posedge clk) disable iff (rst)
        pcm_cen && cen_seen |-> gap_cnt >= 7'd47)
    else begin
        err_cen++;
        $error("pcm_cen pulsed twice within 48 clocks");
    end

endmodule

// ==== bench/cps_sound_tb.sv ====
/*
  testbench for cps_sound. random bus and audio stimulus from a fixed seed,
  checked against a model of RAM, bank and filter bits, ADPCM pole and mixer.
  each bus access is held three clocks and followed by one idle clock
*/
`include "snd_params.svh"

module cps_sound_tb
    import snd_bus_pkg::*;
    import snd_audio_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED = 32'h9a0e;
    localparam int N_RAM = 32;   // write and read pairs
    localparam int N_ROM = 24;   // reads per bank
    localparam int N_IO = 12;    // rounds of five I/O accesses
    localparam int N_MIX = 16;   // samples per mixing run
    localparam int N_SAT = 12;   // samples per saturation step
    localparam int N_BUS_OPS = 2 * N_RAM + 2 * (N_ROM + 1) + 5 * N_IO + 2;
    localparam int N_SAMPLES = 4 * N_MIX + 3 * N_SAT;
    localparam int WATCHDOG_NS = 2 * (N_BUS_OPS * 4 + N_SAMPLES * 48) * 10;
    localparam int BUS = 0;
    localparam int AUDIO = 1;
    localparam int CEN = 2;

    logic          clk;
    logic          rst;
    snd_addr_t     cpu_addr;
    logic          mreq_n;
    logic          rd_n;
    logic          wr_n;
    snd_byte_t     cpu_dout;
    snd_byte_t     cpu_din;
    snd_byte_t     snd_latch0;
    snd_byte_t     snd_latch1;
    logic          enable_fm;
    logic          enable_adpcm;
    snd_rom_addr_t rom_addr;
    logic          rom_cs;
    snd_byte_t     rom_data;
    logic          rom_ok;
    logic          fm_cs;
    logic          fm_wr_n;
    snd_byte_t     fm_dout;
    snd_sample_t   fm_left;
    snd_sample_t   fm_right;
    logic          fm_sample;
    logic          oki_cs;
    logic          oki_wr_n;
    logic          oki_ss;
    logic          pcm_cen;
    snd_byte_t     oki_dout;
    snd_pcm_t      pcm_in;
    logic          pcm_sample;
    snd_sample_t   left;
    snd_sample_t   right;
    logic          peak;

    // model state
    snd_byte_t ram_model [2**`SND_RAM_AW];
    bit        bank_m;
    bit        filt_m;
    int        pole_y;
    int        err_cnt [3];
    int        cen_edges;
    int        cen_last;
    int        cen_pulses;

    cps_sound i_cps_sound (.*);

    bind cps_sound cps_sound_sva i_sva (
        .clk       (clk),
        .rst       (rst),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .fm_cs     (fm_cs),
        .oki_cs    (oki_cs),
        .latch0_cs (latch0_cs),
        .latch1_cs (latch1_cs),
        .peak      (peak),
        .pcm_cen   (pcm_cen)
    );

    // ROM contents, every address bit counts
    function automatic snd_byte_t rom_pattern(input snd_rom_addr_t a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
    endfunction

    assign rom_data = rom_pattern(rom_addr);

    function automatic int pole_model(input int x, input int y, input int coef);
        int       acc;
        snd_pcm_t t;
        acc = (128 - coef) * x + coef * y;
        t = snd_pcm_t'(acc >>> 7); // 14-bit result
        return int'(t);
    endfunction

    function automatic int mix_model(input int ch0, input int ch1, input int g0,
                                     input int g1, output bit sat);
        int s;
        s = (ch0 * g0 + ch1 * g1) >>> 4;
        sat = 1'b0;
        if (s > 32767) begin
            s = 32767;
            sat = 1'b1;
        end else if (s < -32768) begin
            s = -32768;
            sat = 1'b1;
        end
        return s;
    endfunction

    task automatic value_error(input int area, input string what, input int got, input int exp);
        err_cnt[area]++;
        $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
    endtask

    // leaves the access on the bus three clocks
    task automatic bus_access(input snd_addr_t a, input bit is_wr, input snd_byte_t d);
        cpu_addr = a;
        cpu_dout = d;
        mreq_n = 1'b0;
        rd_n = is_wr;
        wr_n = !is_wr;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic bus_idle();
        mreq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic set_bank(input bit v);
        snd_byte_t d;
        d = 8'($urandom);
        d[0] = v;
        bus_access(16'hf004, 1'b1, d);
        bank_m = v;
        bus_idle();
    endtask

    task automatic set_filter(input bit v);
        snd_byte_t d;
        d = 8'($urandom);
        d[0] = v;
        bus_access(16'hf006, 1'b1, d);
        filt_m = v;
        if (oki_ss !== filt_m) value_error(BUS, "oki_ss after filter write", int'(oki_ss), v);
        bus_idle();
    endtask

    // pcm strobe, fm strobe one clock later, 48 clocks in all
    task automatic play_sample(input snd_sample_t fl, input snd_sample_t fr, input snd_pcm_t pcm);
        int g0;
        int g1;
        int exp_l;
        int exp_r;
        bit sat_l;
        bit sat_r;
        pcm_in = pcm;
        pcm_sample = 1'b1;
        @(posedge clk);
        #1;
        pcm_sample = 1'b0;
        pole_y = pole_model(int'(pcm), pole_y,
                            filt_m ? int'(`SND_POLE_HIGH) : int'(`SND_POLE_LOW));
        fm_left = fl;
        fm_right = fr;
        fm_sample = 1'b1;
        @(posedge clk);
        #1;
        fm_sample = 1'b0;
        g0 = enable_fm ? int'(`SND_FM_GAIN) : 0;
        g1 = enable_adpcm ? int'(`SND_PCM_GAIN) : 0;
        exp_l = mix_model(int'(fl), pole_y * 4, g0, g1, sat_l);
        exp_r = mix_model(int'(fr), pole_y * 4, g0, g1, sat_r);
        if (left !== snd_sample_t'(exp_l)) value_error(AUDIO, "left", int'(left), exp_l);
        if (right !== snd_sample_t'(exp_r)) value_error(AUDIO, "right", int'(right), exp_r);
        @(posedge clk);
        #1;
        if (peak !== (sat_l | sat_r)) value_error(AUDIO, "peak", int'(peak), int'(sat_l | sat_r));
        repeat (45) @(posedge clk);
        #1;
    endtask

    task automatic mix_run();
        repeat (N_MIX) play_sample(snd_sample_t'($urandom), snd_sample_t'($urandom),
                                   snd_pcm_t'($urandom));
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // pcm_cen spacing, edges counted from reset release
    always @(posedge clk) begin
        if (!rst) cen_edges++;
    end

    always @(negedge clk) begin
        if (!rst && pcm_cen) begin
            if (cen_edges - cen_last != 48)
                value_error(CEN, "pcm_cen gap in clocks", cen_edges - cen_last, 48);
            cen_last = cen_edges;
            cen_pulses++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the test sequence did not finish",
                 WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin : main
        snd_addr_t     a;
        snd_addr_t     ram_written [$];
        snd_addr_t     pick;
        snd_byte_t     d;
        snd_rom_addr_t exp_rom;
        int            sva_fails;
        rst = 1'b1;
        cpu_addr = '0;
        mreq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        cpu_dout = '0;
        snd_latch0 = '0;
        snd_latch1 = '0;
        enable_fm = 1'b1;
        enable_adpcm = 1'b1;
        rom_ok = 1'b1;
        fm_dout = '0;
        fm_left = '0;
        fm_right = '0;
        fm_sample = 1'b0;
        oki_dout = '0;
        pcm_in = '0;
        pcm_sample = 1'b0;
        void'($urandom(SEED));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        if (cpu_din !== 8'hff) value_error(BUS, "cpu_din after reset", int'(cpu_din), 255);
        if (left !== 16'sd0 || right !== 16'sd0 || peak !== 1'b0)
            value_error(AUDIO, "left after reset", int'(left), 0);

        // work RAM, reads through the mirror at bit 11
        for (int i = 0; i < N_RAM; i++) begin
            a = {4'hd, 12'($urandom)};
            d = 8'($urandom);
            bus_access(a, 1'b1, d);
            ram_model[a[10:0]] = d;
            ram_written.push_back(a);
            bus_idle();
            pick = ram_written[$urandom_range(ram_written.size() - 1, 0)];
            bus_access(pick ^ 16'h0800, 1'b0, 8'h00);
            if (cpu_din !== ram_model[pick[10:0]])
                value_error(BUS, "RAM read", int'(cpu_din), int'(ram_model[pick[10:0]]));
            bus_idle();
        end

        // ROM banking
        for (int b = 0; b < 2; b++) begin
            set_bank(b[0]);
            for (int i = 0; i < N_ROM; i++) begin
                a = 16'($urandom_range(32'hbfff, 0));
                bus_access(a, 1'b0, 8'h00);
                exp_rom = a[15] ? {1'b1, bank_m, a[13:0]} : {1'b0, a[14:0]};
                if (rom_cs !== 1'b1) value_error(BUS, "rom_cs", int'(rom_cs), 1);
                if (rom_addr !== exp_rom)
                    value_error(BUS, "rom_addr", int'(rom_addr), int'(exp_rom));
                if (cpu_din !== rom_pattern(exp_rom))
                    value_error(BUS, "ROM read", int'(cpu_din), int'(rom_pattern(exp_rom)));
                bus_idle();
            end
        end

        // unmapped window, latches, device reads and write strobes
        for (int i = 0; i < N_IO; i++) begin
            bus_access({4'hc, 12'($urandom)}, 1'b0, 8'h00);
            if (cpu_din !== 8'hff) value_error(BUS, "unmapped read", int'(cpu_din), 255);
            if (rom_cs !== 1'b0) value_error(BUS, "rom_cs on unmapped read", int'(rom_cs), 0);
            bus_idle();
            snd_latch0 = 8'($urandom);
            snd_latch1 = 8'($urandom);
            bus_access(i[0] ? 16'hf00a : 16'hf008, 1'b0, 8'h00);
            d = i[0] ? snd_latch1 : snd_latch0;
            if (cpu_din !== d) value_error(BUS, "latch read", int'(cpu_din), int'(d));
            bus_idle();
            fm_dout = 8'($urandom);
            oki_dout = 8'($urandom);
            bus_access(i[0] ? 16'hf002 : 16'hf000, 1'b0, 8'h00);
            d = i[0] ? oki_dout : fm_dout;
            if (cpu_din !== d) value_error(BUS, "device read", int'(cpu_din), int'(d));
            if (fm_cs !== !i[0]) value_error(BUS, "fm_cs", int'(fm_cs), int'(!i[0]));
            if (oki_cs !== i[0]) value_error(BUS, "oki_cs", int'(oki_cs), i[0]);
            bus_idle();
            bus_access(i[0] ? 16'hf002 : 16'hf000, 1'b1, 8'($urandom));
            if (fm_wr_n !== i[0]) value_error(BUS, "fm_wr_n", int'(fm_wr_n), i[0]);
            if (oki_wr_n !== !i[0]) value_error(BUS, "oki_wr_n", int'(oki_wr_n), int'(!i[0]));
            bus_idle();
            if (fm_wr_n !== 1'b1 || oki_wr_n !== 1'b1)
                value_error(BUS, "write strobe after access", int'({fm_wr_n, oki_wr_n}), 3);
            set_filter(1'($urandom));
        end

        // mixing with both poles and each channel muted in turn
        set_filter(1'b0);
        mix_run();
        set_filter(1'b1);
        mix_run();
        enable_fm = 1'b0;
        mix_run();
        enable_fm = 1'b1;
        enable_adpcm = 1'b0;
        mix_run();
        enable_adpcm = 1'b1;

        // saturation both ways, then back in range
        repeat (N_SAT) play_sample(16'sh7fff, 16'sh7fff, 14'sh1fff);
        if (left !== 16'sh7fff || right !== 16'sh7fff || peak !== 1'b1)
            value_error(AUDIO, "positive clamp", int'(left), 32767);
        repeat (N_SAT) play_sample(16'sh8000, 16'sh8000, 14'sh2000);
        if (left !== 16'sh8000 || right !== 16'sh8000 || peak !== 1'b1)
            value_error(AUDIO, "negative clamp", int'(left), -32768);
        repeat (N_SAT) play_sample(16'sd0, 16'sd0, 14'sd0);
        if (peak !== 1'b0) value_error(AUDIO, "peak after in-range samples", int'(peak), 0);

        @(negedge clk);
        #1;
        if (cen_pulses != cen_edges / 48)
            value_error(CEN, "pcm_cen pulse count", cen_pulses, cen_edges / 48);

        sva_fails = i_cps_sound.i_sva.err_excl + i_cps_sound.i_sva.err_rst
                  + i_cps_sound.i_sva.err_cen;
        $display("bus errors %0d, audio errors %0d, cen errors %0d, assertion failures %0d",
                 err_cnt[BUS], err_cnt[AUDIO], err_cnt[CEN], sva_fails);
        if (err_cnt[BUS] + err_cnt[AUDIO] + err_cnt[CEN] + sva_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cps_sound_tb -f sources.f -o cps_sound_sim

./obj_dir/cps_sound_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== sources.f ====
+incdir+verilog
verilog/snd_bus_pkg.sv
verilog/snd_audio_pkg.sv
verilog/snd_addr_decode.sv
verilog/snd_work_ram.sv
verilog/snd_read_mux.sv
verilog/frac_cen.sv
verilog/pole_filter.sv
verilog/audio_mixer.sv
verilog/cps_sound.sv
bench/cps_sound_sva.sv
bench/cps_sound_tb.sv

// ==== verilog/audio_mixer.sv ====
/*
  two-channel mixer with 4.4 gains. result clamps to 16-bit signed range
  and peak marks a clamped sample, both hold until the next sample
*/
module audio_mixer
    import snd_audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sample,
    input  snd_sample_t ch0,
    input  snd_sample_t ch1,
    input  snd_gain_t   gain0,
    input  snd_gain_t   gain1,
    output snd_sample_t mixed,
    output logic        peak
);

    localparam logic signed [25:0] MAX_S = 26'sd32767;
    localparam logic signed [25:0] MIN_S = -26'sd32768;

    logic signed [8:0]  g0;
    logic signed [8:0]  g1;
    logic signed [25:0] sum;
    logic signed [25:0] scaled;

    // gains are unsigned, add a zero sign bit
    assign g0     = $signed({1'b0, gain0});
    assign g1     = $signed({1'b0, gain1});
    assign sum    = ch0 * g0 + ch1 * g1;
    assign scaled = sum >>> 4; // drop the 4 fraction bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else if (sample) begin
            if (scaled > MAX_S) begin
                mixed <= 16'sh7fff;
                peak  <= 1'b1;
            end else if (scaled < MIN_S) begin
                mixed <= 16'sh8000;
                peak  <= 1'b1;
            end else begin
                mixed <= scaled[15:0];
                peak  <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/cps_sound.sv ====
/*
  sound board glue: bus decode, work RAM, read mux, ADPCM clock enable,
  ADPCM low-pass and the stereo mixer. CPU, FM and ADPCM chips are outside.
  rom_ok is only passed on to the external wait logic
*/
`include "snd_params.svh"

module cps_sound
    import snd_bus_pkg::*;
    import snd_audio_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    // sound CPU bus
    input  snd_addr_t     cpu_addr,
    input  logic          mreq_n,
    input  logic          rd_n,
    input  logic          wr_n,
    input  snd_byte_t     cpu_dout,
    output snd_byte_t     cpu_din,
    // from main CPU
    input  snd_byte_t     snd_latch0,
    input  snd_byte_t     snd_latch1,
    input  logic          enable_fm,
    input  logic          enable_adpcm,
    // program ROM
    output snd_rom_addr_t rom_addr,
    output logic          rom_cs,
    input  snd_byte_t     rom_data,
    input  logic          rom_ok,
    // FM chip
    output logic          fm_cs,
    output logic          fm_wr_n,
    input  snd_byte_t     fm_dout,
    input  snd_sample_t   fm_left,
    input  snd_sample_t   fm_right,
    input  logic          fm_sample,
    // ADPCM chip
    output logic          oki_cs,
    output logic          oki_wr_n,
    output logic          oki_ss,
    output logic          pcm_cen,
    input  snd_byte_t     oki_dout,
    input  snd_pcm_t      pcm_in,
    input  logic          pcm_sample,
    // audio out
    output snd_sample_t   left,
    output snd_sample_t   right,
    output logic          peak
);

    logic        ram_cs;
    logic        latch0_cs;
    logic        latch1_cs;
    logic        ram_we;
    snd_byte_t   ram_dout;
    snd_gain_t   fm_gain;
    snd_gain_t   pcm_gain;
    snd_coef_t   pole_coef;
    snd_pcm_t    pcm_pole;
    snd_sample_t pcm_snd;
    logic        peak_l;
    logic        peak_r;

    assign fm_wr_n  = ~(fm_cs & ~wr_n);
    assign oki_wr_n = ~(oki_cs & ~wr_n);
    assign ram_we   = ram_cs & ~wr_n;

    assign fm_gain   = enable_fm ? `SND_FM_GAIN : '0;
    assign pcm_gain  = enable_adpcm ? `SND_PCM_GAIN : '0;
    assign pole_coef = oki_ss ? `SND_POLE_HIGH : `SND_POLE_LOW;
    assign pcm_snd   = {pcm_pole, 2'b00}; // 14 to 16 bits

    snd_addr_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .mreq_n    (mreq_n),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .cpu_dout  (cpu_dout),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .ram_cs    (ram_cs),
        .fm_cs     (fm_cs),
        .oki_cs    (oki_cs),
        .latch0_cs (latch0_cs),
        .latch1_cs (latch1_cs),
        .oki_ss    (oki_ss)
    );

    snd_work_ram #(
        .AW (`SND_RAM_AW)
    ) u_ram (
        .clk   (clk),
        .addr  (cpu_addr[`SND_RAM_AW-1:0]), // mirrored in D000-DFFF
        .we    (ram_we),
        .wdata (cpu_dout),
        .rdata (ram_dout)
    );

    snd_read_mux u_read_mux (
        .clk        (clk),
        .rst        (rst),
        .fm_cs      (fm_cs),
        .oki_cs     (oki_cs),
        .latch0_cs  (latch0_cs),
        .latch1_cs  (latch1_cs),
        .ram_cs     (ram_cs),
        .rom_cs     (rom_cs),
        .snd_latch0 (snd_latch0),
        .snd_latch1 (snd_latch1),
        .fm_dout    (fm_dout),
        .oki_dout   (oki_dout),
        .ram_dout   (ram_dout),
        .rom_data   (rom_data),
        .cpu_din    (cpu_din)
    );

    frac_cen #(
        .N (`SND_CEN_N),
        .M (`SND_CEN_M)
    ) u_pcm_cen (
        .clk (clk),
        .rst (rst),
        .cen (pcm_cen)
    );

    pole_filter u_pole (
        .clk    (clk),
        .rst    (rst),
        .sample (pcm_sample),
        .coef   (pole_coef),
        .sin    (pcm_in),
        .sout   (pcm_pole)
    );

    audio_mixer u_mix_left (
        .clk    (clk),
        .rst    (rst),
        .sample (fm_sample),
        .ch0    (fm_left),
        .ch1    (pcm_snd),
        .gain0  (fm_gain),
        .gain1  (pcm_gain),
        .mixed  (left),
        .peak   (peak_l)
    );

    audio_mixer u_mix_right (
        .clk    (clk),
        .rst    (rst),
        .sample (fm_sample),
        .ch0    (fm_right),
        .ch1    (pcm_snd),
        .gain0  (fm_gain),
        .gain1  (pcm_gain),
        .mixed  (right),
        .peak   (peak_r)
    );

    // either channel clipping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            peak <= 1'b0;
        end else begin
            peak <= peak_l | peak_r;
        end
    end

endmodule

// ==== verilog/frac_cen.sv ====
/*
  fractional clock enable, cen pulses N times every M clocks.
  needs N < M, first pulse M/N clocks after reset
*/
`include "snd_params.svh"

module frac_cen #(
    parameter int N = `SND_CEN_N,
    parameter int M = `SND_CEN_M
) (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    localparam int W = $clog2(M + N) + 1;

    logic [W-1:0] acc;
    logic [W-1:0] sum;

    assign sum = acc + W'(N);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (sum >= W'(M)) begin
            acc <= sum - W'(M); // keep the remainder
            cen <= 1'b1;
        end else begin
            acc <= sum;
            cen <= 1'b0;
        end
    end

endmodule

// ==== verilog/pole_filter.sv ====
/*
  one-pole low-pass, y = ((128-coef)*x + coef*y) >>> 7 on each sample.
  result truncated to 14 bits, holds between samples
*/
module pole_filter
    import snd_audio_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      sample,
    input  snd_coef_t coef,
    input  snd_pcm_t  sin,
    output snd_pcm_t  sout
);

    logic signed [8:0]  k_in;   // 128 - coef, up to 128
    logic signed [8:0]  k_fb;   // coef
    logic signed [23:0] acc;
    logic signed [23:0] shifted;

    assign k_fb    = $signed({2'b00, coef});
    assign k_in    = 9'sd128 - k_fb;
    assign acc     = sin * k_in + sout * k_fb; // full width
    assign shifted = acc >>> 7;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sout <= '0;
        end else if (sample) begin
            sout <= shifted[13:0];
        end
    end

endmodule

// ==== verilog/snd_addr_decode.sv ====
/*
  sound CPU address decoder. selects and rom_addr are registered one clock
  after the bus, so the bus must hold each access for a few clocks.
  only rom_cs looks at rd_n
*/
module snd_addr_decode
    import snd_bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  snd_addr_t     cpu_addr,
    input  logic          mreq_n,
    input  logic          rd_n,
    input  logic          wr_n,
    input  snd_byte_t     cpu_dout,
    output logic          rom_cs,
    output snd_rom_addr_t rom_addr,
    output logic          ram_cs,
    output logic          fm_cs,
    output logic          oki_cs,
    output logic          latch0_cs,
    output logic          latch1_cs,
    output logic          oki_ss
);

    logic     io_sel;
    logic     rom_sel;
    snd_dev_e dev;
    logic     bank_cs;
    logic     filt_cs;
    logic     bank;

    assign io_sel  = !mreq_n && cpu_addr[15:12] == 4'hf;
    // fixed ROM below 8000, banked window at 8000-BFFF
    assign rom_sel = !cpu_addr[15] || cpu_addr[15:14] == 2'b10;
    assign dev     = snd_dev_e'(cpu_addr[3:1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            ram_cs    <= 1'b0;
            fm_cs     <= 1'b0;
            oki_cs    <= 1'b0;
            bank_cs   <= 1'b0;
            filt_cs   <= 1'b0;
            latch0_cs <= 1'b0;
            latch1_cs <= 1'b0;
        end else begin
            rom_cs    <= !mreq_n && !rd_n && rom_sel;
            rom_addr  <= cpu_addr[15] ? {1'b1, bank, cpu_addr[13:0]}
                                      : {1'b0, cpu_addr[14:0]};
            ram_cs    <= !mreq_n && cpu_addr[15:12] == 4'hd;
            fm_cs     <= io_sel && dev == DEV_FM;
            oki_cs    <= io_sel && dev == DEV_OKI;
            bank_cs   <= io_sel && dev == DEV_BANK;
            filt_cs   <= io_sel && dev == DEV_FILT;
            latch0_cs <= io_sel && dev == DEV_LATCH0;
            latch1_cs <= io_sel && dev == DEV_LATCH1;
        end
    end

    // bank and filter-select take bit 0 of the written byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank   <= 1'b0;
            oki_ss <= 1'b0;
        end else if (!wr_n) begin
            if (bank_cs) bank <= cpu_dout[0];
            if (filt_cs) oki_ss <= cpu_dout[0]; // also the ADPCM rate select
        end
    end

endmodule

// ==== verilog/snd_audio_pkg.sv ====
/*
  audio sample, gain and filter coefficient types
*/
package snd_audio_pkg;

    typedef logic signed [15:0] snd_sample_t; // mixer samples
    typedef logic signed [13:0] snd_pcm_t;    // ADPCM decoder output

    // 4.4 fixed point, unsigned
    typedef logic [7:0] snd_gain_t;

    // pole coefficient in 1/128 steps
    typedef logic [6:0] snd_coef_t;

endpackage

// ==== verilog/snd_bus_pkg.sv ====
/*
  sound CPU bus types. I/O slots sit at F000-FFFF and are picked by
  address bits 3:1, slots 6 and 7 are unmapped
*/
package snd_bus_pkg;

    typedef logic [15:0] snd_addr_t;     // CPU address
    typedef logic [7:0]  snd_byte_t;     // CPU data
    typedef logic [15:0] snd_rom_addr_t; // banked ROM address

    // I/O slot, indexed by cpu_addr[3:1]
    typedef enum logic [2:0] {
        DEV_FM     = 3'd0,
        DEV_OKI    = 3'd1,
        DEV_BANK   = 3'd2,
        DEV_FILT   = 3'd3,
        DEV_LATCH0 = 3'd4,
        DEV_LATCH1 = 3'd5
    } snd_dev_e;

endpackage

// ==== verilog/snd_params.svh ====
/*
  sound board constants: work RAM size, mixer gains, ADPCM pole
  coefficients and the ADPCM clock-enable ratio (n/m of the main clock)
*/
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// work RAM address width, 2 KB mirrored over D000-DFFF
`define SND_RAM_AW 11

// mixer gains, 4.4 fixed point
`define SND_FM_GAIN  8'h06
`define SND_PCM_GAIN 8'h18

// ADPCM low-pass pole, picked by the filter-select bit
`define SND_POLE_LOW  7'd104
`define SND_POLE_HIGH 7'd108

// ADPCM clock enable as a fraction of clk
`define SND_CEN_N 1
`define SND_CEN_M 48

`endif

// ==== verilog/snd_read_mux.sv ====
/*
  read data back to the sound CPU through two register stages. cpu_din is
  valid three clocks after a steady address, 8'hff when nothing is selected
*/
module snd_read_mux
    import snd_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fm_cs,
    input  logic      oki_cs,
    input  logic      latch0_cs,
    input  logic      latch1_cs,
    input  logic      ram_cs,
    input  logic      rom_cs,
    input  snd_byte_t snd_latch0,
    input  snd_byte_t snd_latch1,
    input  snd_byte_t fm_dout,
    input  snd_byte_t oki_dout,
    input  snd_byte_t ram_dout,
    input  snd_byte_t rom_data,
    output snd_byte_t cpu_din
);

    snd_byte_t cmd_latch;
    snd_byte_t dev_latch;
    snd_byte_t mem_latch;
    logic      cmd_vld;
    logic      dev_vld;
    logic      mem_vld;

    // stage one data, no reset needed behind the valid bits
    always_ff @(posedge clk) begin
        cmd_latch <= latch0_cs ? snd_latch0 : snd_latch1;
        dev_latch <= fm_cs ? fm_dout : oki_dout;
        mem_latch <= ram_cs ? ram_dout : rom_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_vld <= 1'b0;
            dev_vld <= 1'b0;
            mem_vld <= 1'b0;
        end else begin
            cmd_vld <= latch0_cs | latch1_cs;
            dev_vld <= fm_cs | oki_cs;
            mem_vld <= ram_cs | rom_cs;
        end
    end

    // stage two, devices win over latches, latches over memory
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 8'hff;
        end else if (dev_vld) begin
            cpu_din <= dev_latch;
        end else if (cmd_vld) begin
            cpu_din <= cmd_latch;
        end else if (mem_vld) begin
            cpu_din <= mem_latch;
        end else begin
            cpu_din <= 8'hff; // open bus
        end
    end

endmodule

// ==== verilog/snd_work_ram.sv ====
/*
  single-port work RAM, write on we, read data one clock after addr.
  contents are undefined after power-up
*/
`include "snd_params.svh"

module snd_work_ram
    import snd_bus_pkg::*;
#(
    parameter int AW = `SND_RAM_AW
) (
    input  logic          clk,
    input  logic [AW-1:0] addr,
    input  logic          we,
    input  snd_byte_t     wdata,
    output snd_byte_t     rdata
);

    snd_byte_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr]; // old data on a write cycle
    end

endmodule
